//--- compile.f
design/fetchPkg.sv
design/memPkg.sv
design/pcGen.sv
design/btb.sv
design/memArbiter.sv
design/instrMem.sv
design/fetchTop.sv
dv/fetchTb.sv

//--- Makefile
# Verilator build and run for the fetch subsystem testbench
# all variables can be overridden on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= fetchTb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test OK

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass or fail is read from the log
run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

check:
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "pass" || (echo "fail, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/fetchStimulus.txt
// @00 counts: program words, BTB pairs, redirects, misaligned redirects, reloads
// @10 program words, @20 BTB pc/target, @30 and @40 delay/target, @50 addr/data
@00
0000000c 00000002 00000002 00000002 00000003
@10
00000013 00100093 00200113 00308193
00410213 00518293 00620313 00728393
00830413 00938493 00a40513 00b48593
@20
00000014 00000024
0000002c 00000000
@30
00000007 00000010
0000000d 00000028
@40
00000005 00000006
00000009 00000013
@50
00000008 deadbeef
0000000c 0badf00d
00000024 cafe0001

//--- dv/fetchTb.sv
// testbench for the fetch subsystem, run from the project root
// stimulus comes from dv/fetchStimulus.txt, sections at fixed word offsets
// the model keeps its own memory and BTB, BTB entries are written with run low
// decode is modelled by creditReturn pulses after a pseudo-random delay

`timescale 1ns/100ps

module fetchTb;

  localparam int numCredits = 4;
  // word offsets of the sections in the stimulus file
  localparam int progBase   = 16;
  localparam int btbBase    = 32;
  localparam int redirBase  = 48;
  localparam int faultBase  = 64;
  localparam int reloadBase = 80;

  logic clk;
  logic rst;
  logic run;
  logic loadValid;
  logic [fetchPkg::addrWidth-1:0] loadAddr;
  logic [fetchPkg::instrWidth-1:0] loadData;
  logic loadGrant;
  logic redirect;
  logic [fetchPkg::addrWidth-1:0] redirectPc;
  logic btbUpdate;
  logic [fetchPkg::addrWidth-1:0] btbUpdatePc;
  logic [fetchPkg::addrWidth-1:0] btbUpdateTarget;
  logic instrValid;
  logic [fetchPkg::instrWidth-1:0] instr;
  logic [fetchPkg::addrWidth-1:0] instrPc;
  logic predTaken;
  logic creditReturn;
  logic misalignedFault;

  // model state
  logic [31:0] stim [0:127];
  logic [31:0] modelMem [logic [31:0]];
  logic [31:0] btbPcs [$];
  logic [31:0] btbTargets [$];
  logic [31:0] expectPc;
  logic holdCredits;
  logic faultPending;
  logic stimLoaded;
  integer seed;
  int errorCount;
  int deliveries;
  int returned;
  int owed;
  int returnDelay;
  int loadGrants;
  int mark;
  int cycleLimit;

  fetchTop #(.numCredits(numCredits)) i_dut (
    .clk, .rst, .run, .loadValid, .loadAddr, .loadData, .loadGrant,
    .redirect, .redirectPc, .btbUpdate, .btbUpdatePc, .btbUpdateTarget,
    .instrValid, .instr, .instrPc, .predTaken, .creditReturn, .misalignedFault
  );

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  // every cycle with loadGrant high, sampled once the falling-edge drives settle
  initial begin
    forever begin
      @(negedge clk);
      #1;
      if (!rst && loadGrant) begin
        loadGrants++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference model and checks
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] stimWord(input int idx);
    return stim[7'(idx)];
  endfunction

  function automatic logic modelHit(input logic [31:0] pcVal);
    foreach (btbPcs[i]) begin
      if (btbPcs[i] == pcVal) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // taken on a BTB hit, else the next word
  function automatic logic [31:0] predictNext(input logic [31:0] pcVal);
    foreach (btbPcs[i]) begin
      if (btbPcs[i] == pcVal) begin
        return btbTargets[i];
      end
    end
    return pcVal + 32'd4;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      $display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
      errorCount++;
    end
  endtask

  // one clock: check what the DUT delivered, then act as decode
  task automatic stepCycle();
    @(negedge clk);
    checkValue("misalignedFault", 32'(misalignedFault), 32'(faultPending));
    faultPending = 1'b0;
    if (instrValid) begin
      deliveries++;
      owed++;
      checkValue("instrPc", instrPc, expectPc);
      if (modelMem.exists(expectPc)) begin
        checkValue("instr", instr, modelMem[expectPc]);
      end else begin
        $display("error at %0t: pc %h was fetched but never loaded", $time, expectPc);
        errorCount++;
      end
      checkValue("predTaken", 32'(predTaken), 32'(modelHit(expectPc)));
      // never more instructions held by decode than credits
      checkValue("creditsInUseOk", 32'(deliveries - returned <= numCredits), 32'd1);
      expectPc = predictNext(expectPc);
    end
    creditReturn = 1'b0;
    if (!holdCredits && owed > 0) begin
      if (returnDelay == 0) begin
        creditReturn = 1'b1;
        owed--;
        returned++;
        returnDelay = $random(seed) & 3;
      end else begin
        returnDelay--;
      end
    end
  endtask

  task automatic runCycles(input int n);
    repeat (n) stepCycle();
  endtask

  // hold the request until granted, the word lands at the end of the grant cycle
  task automatic loadWord(input logic [31:0] addr, input logic [31:0] data);
    loadValid = 1'b1;
    loadAddr = addr;
    loadData = data;
    #1;
    while (!loadGrant) begin
      stepCycle();
      #1;
    end
    modelMem[addr] = data;
    stepCycle();
    loadValid = 1'b0;
  endtask

  // a misaligned target only expects a fault, the PC sequence runs on
  task automatic redirectTo(input logic [31:0] target);
    redirect = 1'b1;
    redirectPc = target;
    if (target[1:0] == 2'b00) begin
      expectPc = target;
    end else begin
      faultPending = 1'b1;
    end
    stepCycle();
    redirect = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed = 32'hf68c_299a;
    rst = 1'b1;
    run = 1'b0;
    loadValid = 1'b0;
    loadAddr = '0;
    loadData = '0;
    redirect = 1'b0;
    redirectPc = '0;
    btbUpdate = 1'b0;
    btbUpdatePc = '0;
    btbUpdateTarget = '0;
    creditReturn = 1'b0;
    holdCredits = 1'b0;
    faultPending = 1'b0;
    stimLoaded = 1'b0;
    errorCount = 0;
    deliveries = 0;
    returned = 0;
    owed = 0;
    returnDelay = 0;
    loadGrants = 0;
    // reset vector
    expectPc = '0;
    $readmemh("dv/fetchStimulus.txt", stim);
    cycleLimit = 40 * int'(stimWord(0) + stimWord(1) + stimWord(2) + stimWord(3) + stimWord(4));
    stimLoaded = 1'b1;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    checkValue("instrValid", 32'(instrValid), 32'd0);
    checkValue("loadGrant", 32'(loadGrant), 32'd0);
    checkValue("misalignedFault", 32'(misalignedFault), 32'd0);

    // program load with fetch idle
    for (int i = 0; i < int'(stimWord(0)); i++) begin
      loadWord(32'(i * 4), stimWord(progBase + i));
    end
    checkValue("loadGrantCount", 32'(loadGrants), stimWord(0));
    for (int i = 0; i < int'(stimWord(1)); i++) begin
      btbUpdate = 1'b1;
      btbUpdatePc = stimWord(btbBase + 2 * i);
      btbUpdateTarget = stimWord(btbBase + 2 * i + 1);
      btbPcs.push_back(btbUpdatePc);
      btbTargets.push_back(btbUpdateTarget);
      stepCycle();
    end
    btbUpdate = 1'b0;

    // sequential fetch with predictions
    run = 1'b1;
    runCycles(30);
    checkValue("deliveredAny", 32'(deliveries > 0), 32'd1);

    // credit limit, then resume
    holdCredits = 1'b1;
    mark = deliveries;
    runCycles(20);
    checkValue("holdWithinCredits", 32'(deliveries - mark <= numCredits), 32'd1);
    holdCredits = 1'b0;
    mark = deliveries;
    runCycles(30);
    checkValue("resumed", 32'(deliveries > mark), 32'd1);

    // aligned redirects, then misaligned ones
    for (int i = 0; i < int'(stimWord(2)); i++) begin
      runCycles(int'(stimWord(redirBase + 2 * i)));
      redirectTo(stimWord(redirBase + 2 * i + 1));
    end
    runCycles(20);
    for (int i = 0; i < int'(stimWord(3)); i++) begin
      runCycles(int'(stimWord(faultBase + 2 * i)));
      redirectTo(stimWord(faultBase + 2 * i + 1));
    end
    runCycles(20);

    // rewrites compete with running fetch
    for (int i = 0; i < int'(stimWord(4)); i++) begin
      loadWord(stimWord(reloadBase + 2 * i), stimWord(reloadBase + 2 * i + 1));
    end
    checkValue("loadGrantCount", 32'(loadGrants), stimWord(0) + stimWord(4));
    runCycles(60);
    run = 1'b0;
    runCycles(8);

    $display("errors %0d, instructions %0d, load grants %0d, credits returned %0d",
             errorCount, deliveries, loadGrants, returned);
    if (errorCount == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // watchdog scaled by program length and event count
  initial begin
    wait (stimLoaded);
    repeat (cycleLimit) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", cycleLimit);
    $display("errors %0d, instructions %0d", errorCount, deliveries);
    $display("Test FAILED");
    $finish;
  end

endmodule

//--- design/fetchTop.sv
// instruction fetch subsystem: PC generator, BTB, arbiter and instruction memory
// decode returns one creditReturn pulse per instrValid it consumes
// loadAddr and redirectPc are byte addresses, loads must be word aligned
// memDepth must be a power of two

`timescale 1ns/100ps

module fetchTop #(
  parameter int numCredits = 4,
  parameter int btbEntries = 1 << fetchPkg::btbIndexBits,
  parameter int memDepth   = 1 << memPkg::memAddrBits
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              run,
  input  logic                              loadValid,
  input  logic [fetchPkg::addrWidth-1:0]    loadAddr,
  input  logic [fetchPkg::instrWidth-1:0]   loadData,
  output logic                              loadGrant,
  input  logic                              redirect,
  input  logic [fetchPkg::addrWidth-1:0]    redirectPc,
  input  logic                              btbUpdate,
  input  logic [fetchPkg::addrWidth-1:0]    btbUpdatePc,
  input  logic [fetchPkg::addrWidth-1:0]    btbUpdateTarget,
  output logic                              instrValid,
  output logic [fetchPkg::instrWidth-1:0]   instr,
  output logic [fetchPkg::addrWidth-1:0]    instrPc,
  output logic                              predTaken,
  input  logic                              creditReturn,
  output logic                              misalignedFault
);

  logic [fetchPkg::addrWidth-1:0]   pc;
  logic [fetchPkg::addrWidth-1:0]   btbTarget;
  logic [fetchPkg::instrWidth-1:0]  rdData;
  logic [fetchPkg::instrWidth-1:0]  memWrData;
  logic [$clog2(memDepth)-1:0]      memAddr;
  logic                             btbHit;
  logic                             fetchReq;
  logic                             fetchGrant;
  logic                             memEn;
  logic                             memWe;

  pcGen #(.numCredits(numCredits)) i_pcGen (
    .clk, .rst, .run, .redirect, .redirectPc, .btbHit, .btbTarget,
    .fetchGrant, .rdData, .creditReturn, .pc, .fetchReq,
    .instrValid, .instr, .instrPc, .predTaken, .misalignedFault
  );

  // prediction looks at the PC being fetched right now
  btb #(.btbEntries(btbEntries)) i_btb (
    .clk, .rst, .pc, .btbUpdate, .btbUpdatePc, .btbUpdateTarget, .btbHit, .btbTarget
  );

  memArbiter #(.memDepth(memDepth)) i_memArbiter (
    .clk, .rst, .fetchReq, .fetchAddr(pc), .loadValid, .loadAddr, .loadData,
    .fetchGrant, .loadGrant, .memEn, .memWe, .memAddr, .memWrData
  );

  instrMem #(.memDepth(memDepth)) i_instrMem (
    .clk, .memEn, .memWe, .memAddr, .memWrData, .rdData
  );

endmodule

//--- design/instrMem.sv
// single-port synchronous instruction memory
// a read returns its word one cycle after memEn, a write leaves rdData unchanged
// contents are undefined until written through the load port

`timescale 1ns/100ps

module instrMem #(
  parameter int memDepth = 256
) (
  input  logic                              clk,
  input  logic                              memEn,
  input  logic                              memWe,
  input  logic [$clog2(memDepth)-1:0]       memAddr,
  input  logic [fetchPkg::instrWidth-1:0]   memWrData,
  output logic [fetchPkg::instrWidth-1:0]   rdData
);

  logic [fetchPkg::instrWidth-1:0] memArray [memDepth];

  // read data register doubles as the word handed to decode
  always_ff @(posedge clk) begin
    if (memEn) begin
      if (memWe) begin
        memArray[memAddr] <= memWrData;
      end else begin
        rdData <= memArray[memAddr];
      end
    end
  end

endmodule

//--- design/memArbiter.sv
// round-robin arbiter between fetch reads and program-load writes
// grants are combinational, at most one per cycle
// requesters must hold their request until granted
// both requesters present byte addresses, which become word addresses here

`timescale 1ns/100ps

module memArbiter #(
  parameter int memDepth = 256
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              fetchReq,
  input  logic [fetchPkg::addrWidth-1:0]    fetchAddr,
  input  logic                              loadValid,
  input  logic [fetchPkg::addrWidth-1:0]    loadAddr,
  input  logic [fetchPkg::instrWidth-1:0]   loadData,
  output logic                              fetchGrant,
  output logic                              loadGrant,
  output logic                              memEn,
  output logic                              memWe,
  output logic [$clog2(memDepth)-1:0]       memAddr,
  output logic [fetchPkg::instrWidth-1:0]   memWrData
);

  localparam int wordBits = $clog2(memDepth);

  // id of the requester that wins the next contended cycle
  logic rrPtr;
  logic contended;

  assign contended  = fetchReq & loadValid;
  assign fetchGrant = fetchReq & (~loadValid | (rrPtr == memPkg::reqFetch));
  assign loadGrant  = loadValid & (~fetchReq | (rrPtr == memPkg::reqLoad));

  // single memory port, write only for loads
  assign memEn     = fetchGrant | loadGrant;
  assign memWe     = loadGrant;
  assign memAddr   = loadGrant ? loadAddr[wordBits+1:2] : fetchAddr[wordBits+1:2];
  assign memWrData = loadData;

  always_ff @(posedge clk) begin
    if (rst) begin
      rrPtr <= memPkg::reqFetch;
    end else if (contended) begin
      rrPtr <= (rrPtr == memPkg::reqFetch) ? memPkg::reqLoad : memPkg::reqFetch;
    end
  end

  oneGrant: assert property (@(posedge clk) disable iff (rst) !(fetchGrant && loadGrant))
    else $error("requesters %0d and %0d granted together", memPkg::reqFetch, memPkg::reqLoad);

  // a held load loses at most one contended cycle
  loadNoStarve: assert property (@(posedge clk) disable iff (rst)
    (loadValid && !loadGrant) |=> loadGrant)
    else $error("requester %0d starved", memPkg::reqLoad);

endmodule

//--- design/btb.sv
// direct-mapped branch target buffer
// lookup is combinational on the current PC, an update is visible after the
// next clock edge
// btbEntries must be a power of two and at least 2
// PC bits [1:0] are not stored since every fetch address is word aligned

`timescale 1ns/100ps

module btb #(
  parameter int btbEntries = 8
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [fetchPkg::addrWidth-1:0]    pc,
  input  logic                              btbUpdate,
  input  logic [fetchPkg::addrWidth-1:0]    btbUpdatePc,
  input  logic [fetchPkg::addrWidth-1:0]    btbUpdateTarget,
  output logic                              btbHit,
  output logic [fetchPkg::addrWidth-1:0]    btbTarget
);

  localparam int indexBits = $clog2(btbEntries);
  localparam int tagBits   = fetchPkg::addrWidth - indexBits - 2;

  logic [btbEntries-1:0]            validBits;
  logic [tagBits-1:0]               tagMem [btbEntries];
  logic [fetchPkg::addrWidth-1:0]   targetMem [btbEntries];
  logic [indexBits-1:0]             lookupIdx;
  logic [indexBits-1:0]             updateIdx;
  logic [tagBits-1:0]               lookupTag;
  logic [tagBits-1:0]               updateTag;

  // index from word bits, tag from everything above
  assign lookupIdx = pc[indexBits+1:2];
  assign lookupTag = pc[fetchPkg::addrWidth-1:indexBits+2];
  assign updateIdx = btbUpdatePc[indexBits+1:2];
  assign updateTag = btbUpdatePc[fetchPkg::addrWidth-1:indexBits+2];

  assign btbHit    = validBits[lookupIdx] && (tagMem[lookupIdx] == lookupTag);
  assign btbTarget = targetMem[lookupIdx];

  // only the valid bits are cleared, stale tags are harmless behind them
  always_ff @(posedge clk) begin
    if (rst) begin
      validBits <= '0;
    end else if (btbUpdate) begin
      validBits[updateIdx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (btbUpdate) begin
      tagMem[updateIdx]    <= updateTag;
      targetMem[updateIdx] <= btbUpdateTarget;
    end
  end

endmodule

//--- design/pcGen.sv
// PC generator with credit-based delivery to decode
// the read issued in a grant cycle returns from memory one cycle later and is
// presented to decode in that same cycle, so only one read is ever in flight
// an aligned redirect squashes the read granted in its own cycle
// a misaligned redirect only raises misalignedFault for one cycle
// numCredits must be 1 to 15

`timescale 1ns/100ps

module pcGen #(
  parameter int numCredits = 4
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              run,
  input  logic                              redirect,
  input  logic [fetchPkg::addrWidth-1:0]    redirectPc,
  input  logic                              btbHit,
  input  logic [fetchPkg::addrWidth-1:0]    btbTarget,
  input  logic                              fetchGrant,
  input  logic [fetchPkg::instrWidth-1:0]   rdData,
  input  logic                              creditReturn,
  output logic [fetchPkg::addrWidth-1:0]    pc,
  output logic                              fetchReq,
  output logic                              instrValid,
  output logic [fetchPkg::instrWidth-1:0]   instr,
  output logic [fetchPkg::addrWidth-1:0]    instrPc,
  output logic                              predTaken,
  output logic                              misalignedFault
);

  localparam int creditBits = $clog2(numCredits + 1);

  logic [creditBits-1:0]            creditCnt;
  logic [fetchPkg::addrWidth-1:0]   nextPc;
  logic                             redirectTaken;
  logic                             redirectBad;
  logic                             flightValid;
  logic                             flightSquash;

  // word alignment decides whether a redirect is honoured
  assign redirectBad   = redirect & (|redirectPc[1:0]);
  assign redirectTaken = redirect & ~(|redirectPc[1:0]);

  // ask for the memory only while a credit is held
  assign fetchReq = run & (creditCnt != '0);

  ////////////////////////////////////////////////////////////////////////////
  // next PC: aligned redirect, then BTB hit, then sequential
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    nextPc = pc;
    if (redirectTaken) begin
      nextPc = redirectPc;
    end else if (fetchGrant) begin
      nextPc = btbHit ? btbTarget : pc + fetchPkg::pcStep;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc              <= fetchPkg::resetVector;
      creditCnt       <= creditBits'(numCredits);
      flightValid     <= 1'b0;
      flightSquash    <= 1'b0;
      misalignedFault <= 1'b0;
    end else begin
      pc <= nextPc;
      // a squashed read hands its credit back when its data would have shown up
      creditCnt <= creditCnt + creditBits'(creditReturn) + creditBits'(flightSquash)
                   - creditBits'(fetchGrant);
      flightValid     <= fetchGrant & ~redirectTaken;
      flightSquash    <= fetchGrant & redirectTaken;
      misalignedFault <= redirectBad;
    end
  end

  // in-flight record, captured at grant and handed to decode with the word
  always_ff @(posedge clk) begin
    if (fetchGrant) begin
      instrPc   <= pc;
      predTaken <= btbHit;
    end
  end

  // the memory output register already holds the word for this cycle
  assign instrValid = flightValid;
  assign instr      = rdData;

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////
  creditBound: assert property (@(posedge clk) disable iff (rst)
    creditCnt <= creditBits'(numCredits))
    else $error("credit count %0d above limit %0d", creditCnt, numCredits);

  // squashed slot stays empty, the slot after it carries only the new target
  noSquashedDelivery: assert property (@(posedge clk) disable iff (rst)
    $past(redirectTaken && !rst, 2) |->
      (!$past(instrValid) && (!instrValid || (instrPc == $past(redirectPc, 2)))))
    else $error("old-path read reached decode after a redirect, pc %h", instrPc);

endmodule

//--- design/memPkg.sv
// instruction-memory constants shared by the arbiter and the top level
// the memory is word addressed and holds 2**memAddrBits words by default
// requester ids double as the round-robin pointer value in the arbiter

package memPkg;

  ////////////////////////////////////////////////////////////////////////////
  // memory sizing
  ////////////////////////////////////////////////////////////////////////////

  // word address width, 256 words
  parameter int memAddrBits = 8;

  // requester ids on the single memory port
  parameter logic reqFetch = 1'b0;
  parameter logic reqLoad = 1'b1;

endpackage

//--- design/fetchPkg.sv
// fetch-side constants shared by the PC generator, the BTB and the top level
// every instruction is 32 bits and word aligned, so PC bits [1:0] are always zero
// on a valid fetch address
// the BTB size here is only the default that the top level turns into btbEntries

package fetchPkg;

  ////////////////////////////////////////////////////////////////////////////
  // datapath widths
  ////////////////////////////////////////////////////////////////////////////

  // instruction word as returned by the instruction memory
  parameter int instrWidth = 32;

  // byte address width of the PC
  parameter int addrWidth = 32;

  ////////////////////////////////////////////////////////////////////////////
  // PC sequencing
  ////////////////////////////////////////////////////////////////////////////

  // first fetch address after reset
  parameter logic [addrWidth-1:0] resetVector = '0;

  // sequential step, one full word
  parameter logic [addrWidth-1:0] pcStep = addrWidth'(4);

  // default BTB index width, 8 entries
  parameter int btbIndexBits = 3;

endpackage
